/* Makefile */
# Verilator build and run of the TTC trigger testbench
TOP := ttc_trigger_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -c "TESTS PASSED" > /dev/null

clean:
	rm -rf obj_dir

/* bench/ttc_trigger_properties.sv */
// credit flow and receiver FSM order inside ttc_trigger_subsystem; quiet while reset is high
`timescale 1ns/1ps
`include "ttc_settings.svh"

module ttc_trigger_properties (
  input logic                         clk,
  input logic                         reset,
  input logic                         trigger,
  input logic                         word_valid,       // receiver to FIFO
  input logic                         trig_info_credit,
  input logic                         trig_info_valid,
  input logic                         error_trig_rate,
  input logic                         acq_trigger,
  input ttc_trigger_pkg::recv_state_t recv_state
);
  import ttc_trigger_pkg::*;

  logic [5:0] granted;    // consumer credits not yet used
  logic [5:0] fifo_level; // words written and not yet sent

  always_ff @(posedge clk) begin
    if (reset) begin
      granted    <= '0;
      fifo_level <= '0;
    end else begin
      granted    <= granted + 6'(trig_info_credit) - 6'(trig_info_valid);
      fifo_level <= fifo_level + 6'(word_valid) - 6'(trig_info_valid);
    end
  end

  // a full FIFO leaves the receiver without credit
  credit_held: assert property (@(posedge clk) disable iff (reset)
    word_valid |-> fifo_level < 6'(`TRIG_FIFO_DEPTH))
    else $error("receiver wrote an info word with zero credit");

  grant_held: assert property (@(posedge clk) disable iff (reset)
    trig_info_valid |-> granted != '0)
    else $error("info word sent beyond the granted credits");

  error_sticky: assert property (@(posedge clk) disable iff (reset)
    error_trig_rate |=> error_trig_rate)
    else $error("error_trig_rate fell without reset");

  // decision cycle directly follows a trigger sampled in idle
  acq_after_idle: assert property (@(posedge clk) disable iff (reset)
    acq_trigger |-> $past(recv_state == idle && trigger))
    else $error("acq_trigger outside the cycle after leaving idle");

endmodule

bind ttc_trigger_subsystem ttc_trigger_properties props (
  .clk, .reset, .trigger, .word_valid, .trig_info_credit, .trig_info_valid,
  .error_trig_rate, .acq_trigger,
  .recv_state (receiver.state)
);

/* bench/ttc_trigger_tb.sv */
// triggers are issued only while the receiver is idle; the consumer never holds more than 8 credits
`timescale 1ns/1ps
`include "ttc_settings.svh"

module ttc_trigger_tb;
  import ttc_trigger_pkg::*;
  import acq_channel_pkg::*;

  logic            clk, reset, reset_trig_num, reset_trig_timestamp;
  logic            trigger, async_mode, acq_ready, readout_done, trig_info_credit;
  trig_type_t      trig_type;
  logic [31:0]     trig_settings;
  chan_mask_t      chan_en;
  burst_count_t    burst_count [`NUM_CHAN];
  wfm_count_t      wfm_count [`NUM_CHAN];
  burst_count_t    readout_size, thres_ddr3_overflow;
  logic            acq_trigger, ddr3_almost_full, error_trig_rate, trig_info_valid;
  trig_type_t      acq_trig_type;
  trig_count_t     acq_trig_num, trig_num;
  trig_stamp_t     trig_timestamp;
  burst_count_t    stored_bursts [`NUM_CHAN];
  overflow_count_t ddr3_overflow_count;
  trig_word_t      trig_info_data;

  // reference model
  trig_word_t      expected [$];          // info words in write order
  trig_count_t     next_trig, next_event; // both restart at 1
  trig_stamp_t     stamp;                 // own cycle count
  burst_count_t    stored_m [`NUM_CHAN];
  overflow_count_t overflow_m;
  int              grant_mode;            // 0 withhold, 1 keep ahead, 2 random
  int              unused_grants;         // granted, not yet delivered
  logic            ended;

  ttc_trigger_subsystem dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  always @(posedge clk) begin
    if (reset || reset_trig_timestamp) stamp <= '0;
    else stamp <= stamp + 1'b1;
  end

  task automatic report_failure(input string what);
    ended = 1'b1;
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  // status field compare, up to 64 bits wide
  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    assert (got === want)
      else report_failure($sformatf("MISMATCH %s: got %h expected %h", name, got, want));
  endtask

  // bursts per acquisition including two header bursts
  function automatic burst_count_t acq_size(input int ch);
    return burst_count_t'((int'(burst_count[ch]) + 1) * int'(wfm_count[ch]) + 2);
  endfunction

  function automatic logic model_full();
    logic full;
    full = 1'b0;
    for (int i = 0; i < `NUM_CHAN; i++) begin
      if (chan_en[i] && (`DDR3_CAPACITY - int'(stored_m[i])) < int'(acq_size(i))) full = 1'b1;
    end
    return full;
  endfunction

  // consumer grants at most one credit per cycle
  always @(posedge clk) begin
    logic give;
    #1;
    give = (grant_mode == 1 && unused_grants < 4) ||
           (grant_mode == 2 && unused_grants < 8 && $urandom_range(3) == 0);
    trig_info_credit = give;
    if (give) unused_grants++;
  end

  // scoreboard samples words mid-cycle
  always @(negedge clk) begin
    trig_word_t want;
    if (trig_info_valid) begin
      unused_grants--;
      assert (expected.size() != 0) else report_failure("info word arrived with none pending");
      want = expected.pop_front();
      assert (trig_info_data === want)
        else report_failure($sformatf("MISMATCH trig_info_data: got %h expected %h",
                                      trig_info_data, want));
    end
  end

  task automatic check_status();
    logic warn;
    warn = 1'b0;
    for (int i = 0; i < `NUM_CHAN; i++) begin
      assert (stored_bursts[i] === stored_m[i])
        else report_failure($sformatf("MISMATCH stored_bursts[%0d]: got %h expected %h",
                                      i, stored_bursts[i], stored_m[i]));
      if (stored_m[i] > thres_ddr3_overflow) warn = 1'b1; // any channel, enabled or not
    end
    assert (ddr3_almost_full === warn)
      else report_failure($sformatf("MISMATCH ddr3_almost_full: got %h expected %h",
                                    ddr3_almost_full, warn));
    assert (ddr3_overflow_count === overflow_m)
      else report_failure($sformatf("MISMATCH ddr3_overflow_count: got %h expected %h",
                                    ddr3_overflow_count, overflow_m));
  endtask

  // issues one trigger 1 ns after an edge and returns with the receiver idle again
  task automatic fire(input trig_type_t t);
    logic        pass;
    logic        full;
    trig_stamp_t at; // stamp the trigger edge latches
    full = model_full();
    at   = stamp;
    if (async_mode) pass = (t == `ASYNC_READOUT_TYPE);
    else pass = trig_settings[t] && !full;
    if (acq_ready) expected.push_back({30'd0, !pass, t, next_event, next_trig, stamp});
    trigger   = 1'b1;
    trig_type = t;
    @(posedge clk); // sampled in idle
    #1;
    trigger = 1'b0;
    @(negedge clk); // decision cycle
    assert (acq_trigger === (pass && acq_ready))
      else report_failure($sformatf("MISMATCH acq_trigger: got %h expected %h",
                                    acq_trigger, pass && acq_ready));
    check_field("acq_trig_type", acq_trig_type, t);
    check_field("acq_trig_num", acq_trig_num, next_trig);
    check_field("trig_num", trig_num, trig_count_t'(next_trig + 1'b1));
    check_field("trig_timestamp", trig_timestamp, at);
    next_trig++;
    if (acq_ready && pass) begin
      next_event++;
      for (int i = 0; i < `NUM_CHAN; i++) begin
        if (chan_en[i] && !async_mode) stored_m[i] += acq_size(i);
      end
    end
    if (acq_ready && !async_mode && trig_settings[t] && full) overflow_m++;
    repeat (2) @(posedge clk); // decision edge, then word write
    #1;
    check_status();
  endtask

  task automatic read_out();
    readout_done = 1'b1;
    @(posedge clk);
    #1;
    readout_done = 1'b0;
    for (int i = 0; i < `NUM_CHAN; i++) begin
      if (chan_en[i]) stored_m[i] -= readout_size;
    end
    check_status();
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (expected.size() != 0 && n < limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (expected.size() != 0) report_failure("timeout waiting for info words");
  endtask

  task automatic small_sizes();
    for (int i = 0; i < `NUM_CHAN; i++) begin
      burst_count[i] = burst_count_t'($urandom_range(15, 4));
      wfm_count[i]   = wfm_count_t'($urandom_range(8, 4));
    end
  endtask

  initial begin
    int n;
    void'($urandom(55714));
    {reset_trig_num, reset_trig_timestamp, trigger, async_mode, readout_done} = '0;
    {ended, trig_info_credit, trig_type, overflow_m} = '0;
    reset = 1'b1;
    acq_ready = 1'b1;
    grant_mode = 0;
    unused_grants = 0;
    next_trig = 1;
    next_event = 1;
    trig_settings = 32'h0000_00ff; // types 0 to 7
    chan_en = 5'b10111;
    readout_size = 23'd10;
    thres_ddr3_overflow = 23'd200;
    for (int i = 0; i < `NUM_CHAN; i++) stored_m[i] = '0;
    small_sizes();
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    grant_mode = 1;

    repeat (4) fire(trig_type_t'($urandom_range(7))); // enabled types
    fire(5'd20); // disabled types give empty words
    fire(5'd31);
    wait_drained(100);

    repeat (6) fire(5'd2); // crosses the warning threshold
    read_out();
    read_out();
    for (int i = 0; i < `NUM_CHAN; i++) begin
      burst_count[i] = 23'd8191; // about 2.5M bursts each
      wfm_count[i]   = 12'd300;
    end
    for (int k = 0; k < 6 && !model_full(); k++) fire(5'd2);
    fire(5'd2); // blocked by full DDR3
    fire(5'd5);
    fire(5'd20);
    wait_drained(100);

    async_mode = 1'b1;
    @(posedge clk);
    #1;
    for (int i = 0; i < `NUM_CHAN; i++) stored_m[i] = '0;
    check_status();
    fire(5'd7);
    fire(5'd3);
    fire(5'd7);
    fire(5'd20);
    wait_drained(100);
    async_mode = 1'b0;
    small_sizes();

    grant_mode = 0; // stall the consumer until the receiver runs out of credit
    n = `TRIG_FIFO_DEPTH + 1 + unused_grants;
    repeat (n) fire(trig_type_t'($urandom_range(31)));
    grant_mode = 2;
    wait_drained(2000);
    grant_mode = 1;

    reset_trig_num = 1'b1;
    reset_trig_timestamp = 1'b1;
    @(posedge clk);
    #1;
    {reset_trig_num, reset_trig_timestamp} = '0;
    next_trig = 1;
    next_event = 1;
    fire(5'd1);
    fire(5'd6);
    wait_drained(100);

    acq_ready = 1'b0; // busy channels send the next trigger to error
    fire(5'd1);
    repeat (20) begin
      @(posedge clk);
      #1;
      assert (error_trig_rate === 1'b1)
        else report_failure($sformatf("MISMATCH error_trig_rate: got %h expected 1",
                                      error_trig_rate));
    end

    if (expected.size() == 0) begin
      ended = 1'b1;
      $display("TESTS PASSED");
      $finish;
    end else begin
      report_failure("info words left undelivered");
    end
  end

  // run stopped before the last check
  final begin
    if (!ended) $display("TESTS FAILED");
  end

endmodule

/* source/acq_channel_pkg.sv */
// channel-side types; burst counts wrap at 23 bits, matching one channel's DDR3
`include "ttc_settings.svh"

package acq_channel_pkg;

  // DDR3 bursts
  // used for occupancy, threshold and readout size
  typedef logic [22:0] burst_count_t;

  // waveforms per acquisition
  typedef logic [11:0] wfm_count_t;

  // one enable bit per channel
  typedef logic [`NUM_CHAN-1:0] chan_mask_t;

endpackage

/* source/ddr3_occupancy_tracker.sv */
// occupancy wraps at 2^23 bursts; a trigger and a readout in the same cycle leave it unchanged
`timescale 1ns/1ps
`include "ttc_settings.svh"

module ddr3_occupancy_tracker (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          async_mode,   // occupancy held at zero
  input  logic                          acq_trigger,  // one event per enabled channel
  input  logic                          readout_done, // one event read out
  input  acq_channel_pkg::chan_mask_t   chan_en,
  input  acq_channel_pkg::burst_count_t burst_count [`NUM_CHAN], // bursts per waveform - 1
  input  acq_channel_pkg::wfm_count_t   wfm_count [`NUM_CHAN],
  input  acq_channel_pkg::burst_count_t readout_size,
  input  acq_channel_pkg::burst_count_t thres_ddr3_overflow,
  output acq_channel_pkg::burst_count_t stored_bursts [`NUM_CHAN],
  output logic                          ddr3_full,
  output logic                          ddr3_almost_full
);
  import acq_channel_pkg::*;

  burst_count_t         acq_size [`NUM_CHAN];   // bursts one acquisition takes
  logic [23:0]          free_space [`NUM_CHAN]; // empty channel holds 2^23
  logic [`NUM_CHAN-1:0] chan_full;
  logic [`NUM_CHAN-1:0] chan_warn;

  always_comb begin
    for (int i = 0; i < `NUM_CHAN; i++) begin
      // two header bursts per acquisition
      acq_size[i] = (burst_count[i] + burst_count_t'(1)) * burst_count_t'(wfm_count[i])
                    + burst_count_t'(2);
      free_space[i] = 24'(`DDR3_CAPACITY) - {1'b0, stored_bursts[i]};
      // disabled channels never block
      chan_full[i] = chan_en[i] && (free_space[i] < {1'b0, acq_size[i]});
      chan_warn[i] = stored_bursts[i] > thres_ddr3_overflow; // all channels
    end
  end

  // any channel decides
  assign ddr3_full        = |chan_full;
  assign ddr3_almost_full = |chan_warn;

  always_ff @(posedge clk) begin
    for (int i = 0; i < `NUM_CHAN; i++) begin
      if (reset || async_mode) begin
        stored_bursts[i] <= '0;
      end else if (chan_en[i]) begin
        if (acq_trigger && !readout_done) begin
          stored_bursts[i] <= stored_bursts[i] + acq_size[i];
        end else if (readout_done && !acq_trigger) begin
          stored_bursts[i] <= stored_bursts[i] - readout_size; // command manager sized it
        end
      end
    end
  end

endmodule

/* source/trigger_info_fifo.sv */
// depth must be a power of two; consumer may hold at most 31 unused credits at once
`timescale 1ns/1ps
`include "ttc_settings.svh"

module trigger_info_fifo (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        word_valid,       // receiver holds a credit
  input  ttc_trigger_pkg::trig_word_t word_data,
  input  logic                        trig_info_credit, // consumer grants one word
  output logic                        credit_return,    // slot freed, back to receiver
  output logic                        trig_info_valid,
  output ttc_trigger_pkg::trig_word_t trig_info_data
);
  import ttc_trigger_pkg::*;

  trig_word_t                        mem [`TRIG_FIFO_DEPTH];
  logic [$clog2(`TRIG_FIFO_DEPTH):0] wr_ptr;     // top bit is the wrap flag
  logic [$clog2(`TRIG_FIFO_DEPTH):0] rd_ptr;
  credit_count_t                     out_credit; // words the consumer can take
  logic                              not_empty;
  logic                              send;

  assign not_empty = (wr_ptr != rd_ptr); // equal pointers incl. wrap bit

  // no overflow check on writes, the receiver credit covers it
  // oldest word leaves only with both an entry and a credit
  assign send = not_empty && (out_credit != '0);

  // consumer never stalls, so valid alone completes the transfer
  assign trig_info_valid = send;
  assign trig_info_data  = mem[rd_ptr[$clog2(`TRIG_FIFO_DEPTH)-1:0]];

  // each sent word frees one slot
  assign credit_return = send;

  // storage
  always_ff @(posedge clk) begin
    if (word_valid) begin
      mem[wr_ptr[$clog2(`TRIG_FIFO_DEPTH)-1:0]] <= word_data;
    end
  end

  // pointers and consumer credits
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      out_credit <= '0; // consumer has granted nothing yet
    end else begin
      if (word_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // grant and spend may coincide
      out_credit <= out_credit + credit_count_t'(trig_info_credit)
                    - credit_count_t'(send);
    end
  end

endmodule

/* source/ttc_settings.svh */
// values shared by RTL and testbench; FIFO depth must be a power of two no larger than 16
`ifndef TTC_SETTINGS_SVH
`define TTC_SETTINGS_SVH

// acquisition channels served by one TTC link
`define NUM_CHAN 5

// bursts per channel in DDR3, 2^23
`define DDR3_CAPACITY 8388608

// the only type passed in async mode
`define ASYNC_READOUT_TYPE 5'd7

// info words buffered for the trigger processor
// also the credit the receiver holds out of reset
`define TRIG_FIFO_DEPTH 16

`endif

/* source/ttc_trigger_pkg.sv */
// trigger-side types; widths are fixed by the 128-bit trigger info word format
package ttc_trigger_pkg;

  // TTC trigger type, indexes trig_settings
  typedef logic [4:0] trig_type_t;

  // global trigger number and accepted event number
  typedef logic [23:0] trig_count_t;

  // clock cycles since reset
  typedef logic [43:0] trig_stamp_t;

  // {30'd0, empty, type, event num, trigger num, timestamp}
  typedef logic [127:0] trig_word_t;

  typedef logic [31:0] overflow_count_t; // blocked triggers

  // holds 0 .. TRIG_FIFO_DEPTH
  typedef logic [4:0] credit_count_t;

  // receiver FSM
  typedef enum logic [1:0] {
    idle,            // waiting for a trigger
    send_trigger,    // pass or block decision
    store_trig_info, // write info word once a credit is held
    error            // trigger while channels busy, left only by reset
  } recv_state_t;

endpackage

/* source/ttc_trigger_receiver.sv */
// one trigger in flight; triggers outside idle are dropped; error state is left only by reset
`timescale 1ns/1ps
`include "ttc_settings.svh"

module ttc_trigger_receiver (
  input  logic                             clk,                  // 40 MHz TTC clock
  input  logic                             reset,
  input  logic                             reset_trig_num,       // TTC channel B reset
  input  logic                             reset_trig_timestamp, // TTC channel B reset
  input  logic                             trigger,
  input  ttc_trigger_pkg::trig_type_t      trig_type,
  input  logic [31:0]                      trig_settings,        // enable bit per type
  input  logic                             async_mode,
  input  logic                             acq_ready,            // channels idle
  input  logic                             ddr3_full,            // from occupancy tracker
  input  logic                             credit_return,        // FIFO sent a word
  output logic                             acq_trigger,
  output ttc_trigger_pkg::trig_type_t      acq_trig_type,
  output ttc_trigger_pkg::trig_count_t     acq_trig_num,
  output ttc_trigger_pkg::trig_count_t     trig_num,
  output ttc_trigger_pkg::trig_stamp_t     trig_timestamp,
  output ttc_trigger_pkg::overflow_count_t ddr3_overflow_count,
  output logic                             error_trig_rate,
  output logic                             word_valid,
  output ttc_trigger_pkg::trig_word_t      word_data
);
  import ttc_trigger_pkg::*;

  recv_state_t   state;
  recv_state_t   next_state;
  trig_stamp_t   stamp_cnt;      // free-running cycle count
  trig_count_t   acq_event_cnt;  // next accepted event number
  trig_count_t   word_event_num; // event number as seen at the decision
  credit_count_t credit;         // free slots in the info FIFO
  logic          empty_event;    // word describes a blocked trigger
  logic          trig_start;
  logic          trig_pass;
  logic          overflow;

  assign trig_start = (state == idle) && trigger;

  // decision on the latched type, only meaningful in send_trigger
  always_comb begin
    overflow = 1'b0;
    if (async_mode) begin
      trig_pass = (acq_trig_type == `ASYNC_READOUT_TYPE); // async readout only
    end else begin
      trig_pass = trig_settings[acq_trig_type] && !ddr3_full;
      overflow  = trig_settings[acq_trig_type] && ddr3_full; // enabled, but no room
    end
  end

  // pass to the acquisition controller during send_trigger
  assign acq_trigger = (state == send_trigger) && acq_ready && trig_pass;

  // spends one credit, FSM leaves store_trig_info at the same edge
  assign word_valid = (state == store_trig_info) && (credit != '0);

  assign error_trig_rate = (state == error);

  always_comb begin
    next_state = state;
    case (state)
      idle: begin
        if (trigger) begin
          next_state = send_trigger;
        end
      end
      send_trigger: begin
        // channels still busy with the previous event
        next_state = acq_ready ? store_trig_info : error;
      end
      store_trig_info: begin
        if (credit != '0) begin
          next_state = idle;
        end
      end
      error: begin
        next_state = error; // hard error
      end
      default: begin
        next_state = idle;
      end
    endcase
  end

  // FSM, credits, overflow counter
  always_ff @(posedge clk) begin
    if (reset) begin
      state               <= idle;
      credit              <= credit_count_t'(`TRIG_FIFO_DEPTH); // FIFO starts empty
      ddr3_overflow_count <= '0;
      acq_trig_type       <= '0;
    end else begin
      state  <= next_state;
      credit <= credit - credit_count_t'(word_valid) + credit_count_t'(credit_return);
      if ((state == send_trigger) && acq_ready && overflow) begin
        ddr3_overflow_count <= ddr3_overflow_count + 1'b1;
      end
      if (trig_start) begin
        acq_trig_type <= trig_type;
      end
    end
  end

  // numbering, all start at 1
  always_ff @(posedge clk) begin
    if (reset || reset_trig_num) begin
      trig_num      <= trig_count_t'(1);
      acq_trig_num  <= trig_count_t'(1);
      acq_event_cnt <= trig_count_t'(1);
    end else begin
      if (trig_start) begin
        acq_trig_num <= trig_num;        // number of this trigger
        trig_num     <= trig_num + 1'b1;
      end
      if (acq_trigger) begin
        acq_event_cnt <= acq_event_cnt + 1'b1; // accepted events only
      end
    end
  end

  // timestamp of the trigger edge
  always_ff @(posedge clk) begin
    if (reset || reset_trig_timestamp) begin
      stamp_cnt      <= '0;
      trig_timestamp <= '0;
    end else begin
      stamp_cnt <= stamp_cnt + 1'b1;
      if (trig_start) begin
        trig_timestamp <= stamp_cnt;
      end
    end
  end

  // word fields settled at the end of send_trigger
  always_ff @(posedge clk) begin
    if (state == send_trigger) begin
      empty_event    <= !trig_pass;
      word_event_num <= acq_event_cnt; // pre-increment, so first event is 1
    end
  end

  assign word_data = {30'd0, empty_event, acq_trig_type, word_event_num,
                      acq_trig_num, trig_timestamp};

endmodule

/* source/ttc_trigger_subsystem.sv */
// TTC trigger handling for NUM_CHAN channels; acquisition controller and DDR3 sit outside
`timescale 1ns/1ps
`include "ttc_settings.svh"

module ttc_trigger_subsystem (
  input  logic                             clk,                  // 40 MHz TTC clock
  input  logic                             reset,
  input  logic                             reset_trig_num,
  input  logic                             reset_trig_timestamp,
  input  logic                             trigger,
  input  ttc_trigger_pkg::trig_type_t      trig_type,
  input  logic [31:0]                      trig_settings,
  input  logic                             async_mode,
  input  logic                             acq_ready,
  input  acq_channel_pkg::chan_mask_t      chan_en,
  input  acq_channel_pkg::burst_count_t    burst_count [`NUM_CHAN],
  input  acq_channel_pkg::wfm_count_t      wfm_count [`NUM_CHAN],
  input  acq_channel_pkg::burst_count_t    readout_size,         // from command manager
  input  logic                             readout_done,
  input  acq_channel_pkg::burst_count_t    thres_ddr3_overflow,
  input  logic                             trig_info_credit,     // trigger processor side
  output logic                             acq_trigger,          // to acquisition controller
  output ttc_trigger_pkg::trig_type_t      acq_trig_type,
  output ttc_trigger_pkg::trig_count_t     acq_trig_num,
  output ttc_trigger_pkg::trig_count_t     trig_num,             // status from here down
  output ttc_trigger_pkg::trig_stamp_t     trig_timestamp,
  output acq_channel_pkg::burst_count_t    stored_bursts [`NUM_CHAN],
  output ttc_trigger_pkg::overflow_count_t ddr3_overflow_count,
  output logic                             ddr3_almost_full,
  output logic                             error_trig_rate,
  output logic                             trig_info_valid,
  output ttc_trigger_pkg::trig_word_t      trig_info_data
);
  import ttc_trigger_pkg::*;

  logic       ddr3_full;     // tracker to receiver
  logic       word_valid;    // receiver to FIFO
  trig_word_t word_data;
  logic       credit_return; // FIFO to receiver

  ttc_trigger_receiver receiver (
    .clk, .reset, .reset_trig_num, .reset_trig_timestamp,
    .trigger, .trig_type, .trig_settings, .async_mode, .acq_ready,
    .ddr3_full, .credit_return,
    .acq_trigger, .acq_trig_type, .acq_trig_num, .trig_num, .trig_timestamp,
    .ddr3_overflow_count, .error_trig_rate, .word_valid, .word_data
  );

  ddr3_occupancy_tracker tracker (
    .clk, .reset, .async_mode, .acq_trigger, .readout_done,
    .chan_en, .burst_count, .wfm_count, .readout_size, .thres_ddr3_overflow,
    .stored_bursts, .ddr3_full, .ddr3_almost_full
  );

  trigger_info_fifo info_fifo (
    .clk, .reset, .word_valid, .word_data, .trig_info_credit,
    .credit_return, .trig_info_valid, .trig_info_data
  );

endmodule

/* verilog.f */
+incdir+source
source/ttc_trigger_pkg.sv
source/acq_channel_pkg.sv
source/ttc_trigger_receiver.sv
source/ddr3_occupancy_tracker.sv
source/trigger_info_fifo.sv
source/ttc_trigger_subsystem.sv
bench/ttc_trigger_properties.sv
bench/ttc_trigger_tb.sv
